// File: Bender.yml
package:
  name: page_cpu

sources:
  - page_cpu_pkg.sv
  - mmu_lookup_if.sv
  - program_ram.sv
  - page_mmu.sv
  - fetch_decode_core.sv
  - trace_fifo.sv
  - uart_tx.sv
  - page_cpu_top.sv
  - target: test
    files:
      - tb_page_cpu.sv

// File: fetch_decode_core.sv
`timescale 1ns/1ps

module fetch_decode_core #(
  parameter page_cpu_pkg::addr_t START_PC = 8'd0
) (
  input  logic clk,
  input  logic reset,
  input  logic start,
  mmu_lookup_if.core lookup,
  output page_cpu_pkg::addr_t fetch_addr,
  input  page_cpu_pkg::word_t fetch_data,
  output logic push,
  output page_cpu_pkg::char_t push_data,
  input  logic full
);
  import page_cpu_pkg::*;

  core_state_t state;
  core_state_t emit_next;  // where EMIT goes once the character is out
  core_state_t xlate_ret;  // where TRANSLATE goes on a hit
  addr_t pc;  // logical address of the next word to fetch
  addr_t pc_inc;
  addr_t next_pc;
  page_t cur_page;
  seg_t cur_seg;
  word_t instr1;
  word_t regs [REGS];
  char_t emit_char;
  logic word1_due;  // first word lands on the ram port this cycle
  logic [7:0] opcode;
  reg_idx_t rd;

  function automatic page_t page_of(addr_t a);
    return a[$bits(addr_t)-1:OFFSET_BITS];
  endfunction

  assign opcode = instr1[15:8];
  assign rd = instr1[3:0];
  assign pc_inc = pc + 1'b1;
  assign next_pc = (opcode == OPCODE_JMP) ? fetch_data[7:0] : pc;  // operand is the target
  assign fetch_addr = {cur_seg, pc[OFFSET_BITS-1:0]};  // segment * PAGE_WORDS + offset
  assign push = (state == EMIT) && !full;
  assign push_data = emit_char;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      lookup.req <= 1'b0;
      word1_due <= 1'b0;
    end else begin
      lookup.req <= 1'b0;
      word1_due <= (state == FETCH1);
      if (word1_due) begin
        instr1 <= fetch_data;
      end
      case (state)
        IDLE: begin
          if (start) begin
            pc <= START_PC;
            emit_char <= CHAR_START;
            emit_next <= TRANSLATE;  // first page is always looked up
            state <= EMIT;
          end
        end
        FETCH1: begin
          pc <= pc_inc;
          if (page_of(pc_inc) != cur_page) begin  // operand sits on the next page
            lookup.req <= 1'b1;
            lookup.logical_page <= page_of(pc_inc);
            xlate_ret <= FETCH2;
            state <= TRANSLATE;
          end else begin
            state <= FETCH2;
          end
        end
        FETCH2: begin
          pc <= pc_inc;
          state <= EXEC;
        end
        EXEC: begin
          pc <= next_pc;
          state <= EMIT;
          emit_next <= (page_of(next_pc) != cur_page) ? TRANSLATE : FETCH1;
          case (opcode)
            OPCODE_NUM2REG: emit_char <= CHAR_NUM2REG;
            OPCODE_REG2OUT: emit_char <= regs[rd][7:0];
            OPCODE_JMP: emit_char <= CHAR_JMP;
            OPCODE_HALT: begin
              emit_char <= CHAR_HALT;
              emit_next <= HALTED;
            end
            default: emit_char <= CHAR_UNKNOWN;  // skipped, pc already at pc+2
          endcase
        end
        TRANSLATE: begin
          if (lookup.done) begin
            if (lookup.found) begin
              cur_seg <= lookup.segment;
              cur_page <= lookup.logical_page;
              state <= xlate_ret;
            end else begin
              emit_char <= CHAR_FAULT;
              emit_next <= HALTED;
              state <= EMIT;
            end
          end
        end
        EMIT: begin
          if (!full) begin
            state <= emit_next;
            if (emit_next == TRANSLATE) begin
              lookup.req <= 1'b1;
              lookup.logical_page <= page_of(pc);
              xlate_ret <= FETCH1;
            end
          end
        end
        HALTED: state <= HALTED;  // left only through reset
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (state == EXEC && opcode == OPCODE_NUM2REG) begin
      regs[rd] <= fetch_data;
    end
  end

  // the walker only answers a request the core is waiting on
  assert property (@(posedge clk) disable iff (reset) lookup.done |-> state == TRANSLATE)
    else $error("mmu answer outside a translation");

endmodule

// File: mmu_lookup_if.sv
`timescale 1ns/1ps

interface mmu_lookup_if;
  import page_cpu_pkg::*;

  logic req;  // one-cycle strobe from the core
  page_t logical_page;  // held by the core until done
  logic done;  // one-cycle pulse at the end of the walk
  logic found;
  seg_t segment;  // valid with done when found is high

  modport core (
    output req, logical_page,
    input done, found, segment
  );

  modport mmu (
    input req, logical_page,
    output done, found, segment
  );

endinterface

// File: page_cpu_pkg.sv
package page_cpu_pkg;

  localparam int RAM_WORDS = 256;
  localparam int PAGE_WORDS = 8;  // words per page and per segment
  localparam int OFFSET_BITS = $clog2(PAGE_WORDS);
  localparam int SEGMENTS = 32;
  localparam int REGS = 16;

  typedef logic [15:0] word_t;  // ram word, instruction word or register value
  typedef logic [7:0] addr_t;  // word address, logical or physical
  typedef logic [4:0] seg_t;  // physical segment index
  typedef logic [4:0] page_t;  // logical page number
  typedef logic [3:0] reg_idx_t;
  typedef logic [7:0] char_t;  // one trace character

  // upper byte of the first instruction word
  localparam logic [7:0] OPCODE_JMP = 8'd1;
  localparam logic [7:0] OPCODE_REG2OUT = 8'd9;
  localparam logic [7:0] OPCODE_NUM2REG = 8'd14;
  localparam logic [7:0] OPCODE_HALT = 8'd15;

  localparam char_t CHAR_START = "S";
  localparam char_t CHAR_JMP = "1";
  localparam char_t CHAR_NUM2REG = "4";
  localparam char_t CHAR_HALT = "H";
  localparam char_t CHAR_UNKNOWN = "X";
  localparam char_t CHAR_FAULT = "F";

  typedef enum logic [2:0] {
    IDLE,
    FETCH1,  // present first word address
    FETCH2,  // present operand address, first word arrives
    EXEC,
    TRANSLATE,  // waiting on the mmu walker
    EMIT,  // holds one character until the fifo has room
    HALTED
  } core_state_t;

endpackage

// File: page_cpu_top.f
page_cpu_pkg.sv
mmu_lookup_if.sv
program_ram.sv
page_mmu.sv
fetch_decode_core.sv
trace_fifo.sv
uart_tx.sv
page_cpu_top.sv
tb_page_cpu.sv

// File: page_cpu_top.sv
`timescale 1ns/1ps

module page_cpu_top #(
  parameter int CLKS_PER_BIT = 868,
  parameter int FIFO_DEPTH = 128,
  parameter page_cpu_pkg::addr_t START_PC = 8'd0
) (
  input  logic clk,
  input  logic reset,
  input  logic start,
  input  logic load_we,
  input  page_cpu_pkg::addr_t load_addr,
  input  page_cpu_pkg::word_t load_data,
  input  logic map_we,
  input  page_cpu_pkg::seg_t map_segment,
  input  page_cpu_pkg::seg_t map_next,
  input  page_cpu_pkg::page_t map_page,
  output logic tx
);
  import page_cpu_pkg::*;

  addr_t fetch_addr;
  word_t fetch_data;
  logic push;
  char_t push_data;
  logic full;
  logic pop;
  char_t pop_data;
  logic empty;

  mmu_lookup_if lookup ();

  program_ram u_program_ram (
    .clk(clk), .load_we(load_we), .load_addr(load_addr), .load_data(load_data),
    .fetch_addr(fetch_addr), .fetch_data(fetch_data)
  );

  page_mmu u_page_mmu (
    .clk(clk), .reset(reset), .map_we(map_we), .map_segment(map_segment),
    .map_next(map_next), .map_page(map_page), .lookup(lookup.mmu)
  );

  fetch_decode_core #(.START_PC(START_PC)) u_fetch_decode_core (
    .clk(clk), .reset(reset), .start(start), .lookup(lookup.core),
    .fetch_addr(fetch_addr), .fetch_data(fetch_data),
    .push(push), .push_data(push_data), .full(full)
  );

  trace_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_trace_fifo (
    .clk(clk), .reset(reset), .push(push), .push_data(push_data),
    .pop(pop), .pop_data(pop_data), .full(full), .empty(empty)
  );

  uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_tx (
    .clk(clk), .reset(reset), .empty(empty), .pop_data(pop_data), .pop(pop), .tx(tx)
  );

endmodule

// File: page_mmu.sv
`timescale 1ns/1ps

module page_mmu (
  input  logic clk,
  input  logic reset,
  input  logic map_we,
  input  page_cpu_pkg::seg_t map_segment,
  input  page_cpu_pkg::seg_t map_next,
  input  page_cpu_pkg::page_t map_page,
  mmu_lookup_if.mmu lookup
);
  import page_cpu_pkg::*;

  localparam int HOP_W = $clog2(SEGMENTS);

  seg_t next_link [SEGMENTS];  // self link marks the chain end
  page_t tag [SEGMENTS];  // logical page held by each segment
  logic [SEGMENTS-1:0] valid;

  logic walking;
  seg_t walk_seg;  // segment visited this cycle
  page_t walk_page;
  logic [HOP_W-1:0] hops;  // bounds a walk to SEGMENTS visits
  logic hit;
  logic chain_end;

  assign hit = valid[walk_seg] && (tag[walk_seg] == walk_page);
  assign chain_end = !valid[walk_seg] || (next_link[walk_seg] == walk_seg) ||
                     (hops == HOP_W'(SEGMENTS - 1));

  assign lookup.done = walking && (hit || chain_end);
  assign lookup.found = hit;
  assign lookup.segment = walk_seg;

  always_ff @(posedge clk) begin
    if (map_we) begin
      next_link[map_segment] <= map_next;
      tag[map_segment] <= map_page;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= '0;
    end else if (map_we) begin
      valid[map_segment] <= 1'b1;
    end
  end

  // every walk begins at segment 0
  always_ff @(posedge clk) begin
    if (reset) begin
      walking <= 1'b0;
    end else if (lookup.req) begin
      walking <= 1'b1;
      walk_seg <= '0;
      walk_page <= lookup.logical_page;
      hops <= '0;
    end else if (lookup.done) begin
      walking <= 1'b0;
    end else if (walking) begin
      walk_seg <= next_link[walk_seg];  // one hop per cycle
      hops <= hops + 1'b1;
    end
  end

  assert property (@(posedge clk) disable iff (reset) lookup.req |-> !walking)
    else $error("translation request during an active walk");

endmodule

// File: program_ram.sv
`timescale 1ns/1ps

module program_ram (
  input  logic clk,
  input  logic load_we,
  input  page_cpu_pkg::addr_t load_addr,
  input  page_cpu_pkg::word_t load_data,
  input  page_cpu_pkg::addr_t fetch_addr,
  output page_cpu_pkg::word_t fetch_data
);
  import page_cpu_pkg::*;

  word_t mem [RAM_WORDS];

  always_ff @(posedge clk) begin
    if (load_we) begin
      mem[load_addr] <= load_data;
    end
  end

  // read port registered every cycle, data one cycle after the address
  always_ff @(posedge clk) begin
    fetch_data <= mem[fetch_addr];
  end

endmodule

// File: tb_page_cpu.sv
`timescale 1ns/1ps

module tb_page_cpu;
  import page_cpu_pkg::*;

  localparam int CLKS_PER_BIT = 4;
  localparam int NUM_TESTS = 7;
  localparam int MAX_WORDS = 32;
  localparam int MAX_ROWS = 4;
  localparam int MAX_CHARS = 24;
  localparam int WAIT_LIMIT = 2000;  // cycles allowed before each start bit
  localparam int SILENCE = 400;  // quiet cycles expected after the last character

  logic clk;
  logic reset;
  logic start;
  logic load_we;
  addr_t load_addr;
  word_t load_data;
  logic map_we;
  seg_t map_segment;
  seg_t map_next;
  page_t map_page;
  logic tx;

  // test table, programs are indexed by logical address
  word_t prog [NUM_TESTS][MAX_WORDS];
  int prog_len [NUM_TESTS];
  seg_t row_seg [NUM_TESTS][MAX_ROWS];
  seg_t row_next [NUM_TESTS][MAX_ROWS];
  page_t row_page [NUM_TESTS][MAX_ROWS];
  int row_cnt [NUM_TESTS];
  char_t exp_chars [NUM_TESTS][MAX_CHARS];
  int exp_len [NUM_TESTS];
  string test_name [NUM_TESTS];
  logic [15:0] lfsr = 16'd96;
  int pass_cnt;
  int fail_cnt;

  page_cpu_top #(
    .CLKS_PER_BIT(CLKS_PER_BIT), .FIFO_DEPTH(4), .START_PC(8'd0)
  ) u_page_cpu_top (
    .clk(clk), .reset(reset), .start(start),
    .load_we(load_we), .load_addr(load_addr), .load_data(load_data),
    .map_we(map_we), .map_segment(map_segment), .map_next(map_next),
    .map_page(map_page), .tx(tx)
  );

  // galois lfsr, taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic draw_word(output word_t v);
    for (int i = 0; i < 16; i++) begin
      v[i] = lfsr[0];  // one step per bit
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic put_instr(int t, int a, logic [7:0] op, reg_idx_t rd, word_t operand);
    prog[t][a] = {op, 4'h0, rd};
    prog[t][a + 1] = operand;
    if (a + 2 > prog_len[t]) prog_len[t] = a + 2;
  endtask

  task automatic add_row(int t, seg_t seg, seg_t next, page_t page);
    row_seg[t][row_cnt[t]] = seg;
    row_next[t][row_cnt[t]] = next;
    row_page[t][row_cnt[t]] = page;
    row_cnt[t]++;
  endtask

  task automatic add_expected(int t, char_t c);
    exp_chars[t][exp_len[t]] = c;
    exp_len[t]++;
  endtask

  // segment p holds page p, the last one links to itself
  task automatic map_identity(int t, int pages);
    for (int p = 0; p < pages; p++) begin
      add_row(t, seg_t'(p), seg_t'((p == pages - 1) ? p : p + 1), page_t'(p));
    end
  endtask

  task automatic build_tests();
    word_t v [5];
    for (int t = 0; t < NUM_TESTS; t++) begin
      prog_len[t] = 0;
      row_cnt[t] = 0;
      exp_len[t] = 0;
      for (int a = 0; a < MAX_WORDS; a++) begin
        prog[t][a] = {8'hA5, 8'(a)};  // filler, traces X if ever executed
      end
      add_expected(t, CHAR_START);
    end
    test_name[0] = "registers";
    draw_word(v[0]);
    draw_word(v[1]);
    put_instr(0, 0, OPCODE_NUM2REG, 4'd3, v[0]);
    put_instr(0, 2, OPCODE_REG2OUT, 4'd3, 16'h0);
    put_instr(0, 4, OPCODE_NUM2REG, 4'd12, v[1]);
    put_instr(0, 6, OPCODE_REG2OUT, 4'd12, 16'h0);
    put_instr(0, 8, OPCODE_HALT, 4'd0, 16'h0);
    map_identity(0, 2);
    add_expected(0, CHAR_NUM2REG);
    add_expected(0, v[0][7:0]);
    add_expected(0, CHAR_NUM2REG);
    add_expected(0, v[1][7:0]);
    add_expected(0, CHAR_HALT);
    // same straight-line program under an identity map and a chained map
    test_name[1] = "identity map";
    test_name[2] = "chained map";
    for (int i = 0; i < 5; i++) draw_word(v[i]);
    for (int t = 1; t <= 2; t++) begin
      for (int i = 0; i < 5; i++) begin
        put_instr(t, 4 * i, OPCODE_NUM2REG, reg_idx_t'(i + 1), v[i]);
        put_instr(t, 4 * i + 2, OPCODE_REG2OUT, reg_idx_t'(i + 1), 16'h0);
        add_expected(t, CHAR_NUM2REG);
        add_expected(t, v[i][7:0]);
      end
      put_instr(t, 20, OPCODE_HALT, 4'd0, 16'h0);
      add_expected(t, CHAR_HALT);
    end
    map_identity(1, 3);
    add_row(2, 5'd0, 5'd3, 5'd0);
    add_row(2, 5'd3, 5'd7, 5'd2);
    add_row(2, 5'd7, 5'd7, 5'd1);
    test_name[3] = "jump";
    put_instr(3, 0, OPCODE_JMP, 4'd0, 16'd15);
    put_instr(3, 2, OPCODE_NUM2REG, 4'd5, 16'h00AB);  // jumped over
    put_instr(3, 15, OPCODE_REG2OUT, 4'd5, 16'h0);  // straddles pages 1 and 2
    put_instr(3, 17, OPCODE_HALT, 4'd0, 16'h0);
    map_identity(3, 3);
    add_expected(3, CHAR_JMP);
    add_expected(3, 8'h00);
    add_expected(3, CHAR_HALT);
    test_name[4] = "unknown opcode";
    draw_word(v[0]);
    put_instr(4, 0, 8'd5, 4'd0, 16'h0);
    put_instr(4, 2, OPCODE_NUM2REG, 4'd1, v[0]);
    put_instr(4, 4, OPCODE_REG2OUT, 4'd1, 16'h0);
    put_instr(4, 6, OPCODE_HALT, 4'd0, 16'h0);
    map_identity(4, 1);
    add_expected(4, CHAR_UNKNOWN);
    add_expected(4, CHAR_NUM2REG);
    add_expected(4, v[0][7:0]);
    add_expected(4, CHAR_HALT);
    test_name[5] = "fault";
    put_instr(5, 0, OPCODE_JMP, 4'd0, 16'h0040);  // page 8 is not mapped
    map_identity(5, 1);
    add_expected(5, CHAR_JMP);
    add_expected(5, CHAR_FAULT);
    test_name[6] = "back-pressure";
    draw_word(v[0]);
    draw_word(v[1]);
    put_instr(6, 0, OPCODE_NUM2REG, 4'd1, v[0]);
    put_instr(6, 2, OPCODE_NUM2REG, 4'd2, v[1]);
    add_expected(6, CHAR_NUM2REG);
    add_expected(6, CHAR_NUM2REG);
    for (int i = 0; i < 12; i++) begin
      put_instr(6, 4 + 2 * i, OPCODE_REG2OUT, reg_idx_t'(i % 2 + 1), 16'h0);
      add_expected(6, v[i % 2][7:0]);
    end
    put_instr(6, 28, OPCODE_HALT, 4'd0, 16'h0);
    add_expected(6, CHAR_HALT);
    map_identity(6, 4);
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1;
    reset = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
  endtask

  // page table first, then each program word at its physical address
  task automatic load_test(int t);
    for (int r = 0; r < row_cnt[t]; r++) begin
      map_we = 1'b1;
      map_segment = row_seg[t][r];
      map_next = row_next[t][r];
      map_page = row_page[t][r];
      @(posedge clk);
      #1;
    end
    map_we = 1'b0;
    for (int a = 0; a < prog_len[t]; a++) begin
      for (int r = 0; r < row_cnt[t]; r++) begin
        if (row_page[t][r] == page_t'(a / PAGE_WORDS)) begin
          load_we = 1'b1;
          load_addr = addr_t'(row_seg[t][r] * PAGE_WORDS + a % PAGE_WORDS);
          load_data = prog[t][a];
          @(posedge clk);
          #1;
        end
      end
    end
    load_we = 1'b0;
  endtask

  // waits for a start bit, then samples each bit in the middle of its time
  task automatic receive_char(input int limit, output char_t c, output logic got);
    int n;
    n = 0;
    got = 1'b0;
    c = '0;
    while (n < limit && tx !== 1'b0) begin
      @(negedge clk);
      n++;
    end
    if (tx === 1'b0) begin
      repeat (CLKS_PER_BIT / 2) @(negedge clk);
      for (int i = 0; i < 8; i++) begin
        repeat (CLKS_PER_BIT) @(negedge clk);
        c[i] = tx;
      end
      repeat (CLKS_PER_BIT) @(negedge clk);
      got = (tx === 1'b1);  // stop bit
    end
  endtask

  task automatic check_silence(output logic quiet);
    quiet = 1'b1;
    for (int n = 0; n < SILENCE; n++) begin
      @(negedge clk);
      if (tx !== 1'b1) quiet = 1'b0;
    end
  endtask

  task automatic run_test(int t);
    char_t c;
    logic got;
    logic quiet;
    int errs;
    errs = 0;
    apply_reset();
    load_test(t);
    start = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    for (int i = 0; i < exp_len[t]; i++) begin
      receive_char(WAIT_LIMIT, c, got);
      assert (got) else begin
        $display("test %0d: no valid character %0d arrived within %0d cycles",
                 t, i, WAIT_LIMIT);
        errs++;
      end
      if (!got) break;
      assert (c == exp_chars[t][i]) else begin
        $display("ERR %0t: test %0d char %0d expected 8'h%02h received 8'h%02h",
                 $time, t, i, exp_chars[t][i], c);
        errs++;
      end
    end
    check_silence(quiet);
    assert (quiet) else begin
      $display("test %0d: serial line still active after the last expected character", t);
      errs++;
    end
    $display("test %0d %s: %s", t, test_name[t], (errs == 0) ? "ok" : "mismatch");
    if (errs == 0) pass_cnt++;
    else fail_cnt++;
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    start = 1'b0;
    load_we = 1'b0;
    load_addr = '0;
    load_data = '0;
    map_we = 1'b0;
    map_segment = '0;
    map_next = '0;
    map_page = '0;
    pass_cnt = 0;
    fail_cnt = 0;
    build_tests();
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: trace_fifo.sv
`timescale 1ns/1ps

module trace_fifo #(
  parameter int FIFO_DEPTH = 128
) (
  input  logic clk,
  input  logic reset,
  input  logic push,
  input  page_cpu_pkg::char_t push_data,
  input  logic pop,
  output page_cpu_pkg::char_t pop_data,
  output logic full,
  output logic empty
);
  import page_cpu_pkg::*;

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  char_t mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic do_push;
  logic do_pop;

  assign do_push = push && !full;
  assign do_pop = pop && !empty;
  assign full = (count == CNT_W'(FIFO_DEPTH));
  assign empty = (count == '0);
  assign pop_data = mem[rd_ptr];  // head is visible before the pop

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  assert property (@(posedge clk) disable iff (reset) pop |-> !empty)
    else $error("trace fifo popped while empty");

endmodule

// File: uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
  parameter int CLKS_PER_BIT = 868
) (
  input  logic clk,
  input  logic reset,
  input  logic empty,
  input  page_cpu_pkg::char_t pop_data,
  output logic pop,
  output logic tx
);
  import page_cpu_pkg::*;

  localparam int CLK_W = $clog2(CLKS_PER_BIT + 1);
  localparam int FRAME_BITS = $bits(char_t) + 2;  // start, data, stop

  logic busy;
  logic [FRAME_BITS-1:0] frame;  // shifted out lsb first
  logic [3:0] bit_cnt;
  logic [CLK_W-1:0] clk_cnt;

  assign pop = !busy && !empty;
  assign tx = busy ? frame[0] : 1'b1;  // line idles high

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
    end else if (pop) begin
      busy <= 1'b1;
      frame <= {1'b1, pop_data, 1'b0};
      bit_cnt <= '0;
      clk_cnt <= '0;
    end else if (busy) begin
      if (clk_cnt == CLK_W'(CLKS_PER_BIT - 1)) begin  // end of one bit time
        clk_cnt <= '0;
        frame <= {1'b1, frame[FRAME_BITS-1:1]};
        if (bit_cnt == 4'(FRAME_BITS - 1)) begin
          busy <= 1'b0;  // stop bit done
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end else begin
        clk_cnt <= clk_cnt + 1'b1;
      end
    end
  end

endmodule
